/* hw/cnn_pkg.sv */
// CNN engine shared definitions
package cnn_pkg;

	localparam int CONV_LANES = 4;
	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int LANE_W = $clog2(CONV_LANES);
	localparam int OP_NUM_W = 8;
	// Read count for the longest convolution over all lanes
	localparam int RD_CNT_W = OP_NUM_W + LANE_W;

	typedef enum logic [2:0] {
		OP_NONE      = 3'd0,
		OP_CONV_CH0  = 3'd1,
		OP_CONV_CH1  = 3'd2,
		OP_CONV_DUAL = 3'd3,
		OP_MPOOL     = 3'd4,
		OP_APOOL     = 3'd5
	} op_e;

	// Presented with start and held until done
	typedef struct packed {
		op_e                 op;
		logic [OP_NUM_W-1:0] op_num;
		logic [2:0]          avg_shift;
	} cmd_t;

	typedef struct packed {
		logic [15:0] data;
		logic [15:0] weight;
	} operand_t;

	typedef struct packed {
		logic        wr_en;
		logic [15:0] value;
	} result_t;

endpackage

/* hw/operand_fifo.sv */
// Operand stream FIFO
module operand_fifo (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  cnn_pkg::operand_t push_data,
	input  logic              rd,
	output cnn_pkg::operand_t head,
	output logic              empty,
	output logic              full
);

	cnn_pkg::operand_t mem [cnn_pkg::FIFO_DEPTH];

	// Extra top bit tells a full buffer from an empty one
	logic [cnn_pkg::FIFO_AW:0] wr_ptr;
	logic [cnn_pkg::FIFO_AW:0] rd_ptr;

	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[cnn_pkg::FIFO_AW] != rd_ptr[cnn_pkg::FIFO_AW]) &&
		(wr_ptr[cnn_pkg::FIFO_AW-1:0] == rd_ptr[cnn_pkg::FIFO_AW-1:0]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (rd) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Head word is valid the clock after the read
	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr[cnn_pkg::FIFO_AW-1:0]] <= push_data;
		if (rd) head <= mem[rd_ptr[cnn_pkg::FIFO_AW-1:0]];
	end

	assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("push into a full operand FIFO");

	assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
		else $error("read from an empty operand FIFO");

endmodule

/* hw/cmac.sv */
// Multiply-accumulate lane
module cmac (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         clear,
	input  logic                         load,
	input  cnn_pkg::operand_t            operand,
	input  logic [cnn_pkg::OP_NUM_W-1:0] op_num,
	output logic                         full,
	output logic [15:0]                  result
);

	logic [cnn_pkg::OP_NUM_W-1:0] cnt;
	logic [31:0]                  product;
	logic [15:0]                  sum;

	assign product = operand.data * operand.weight;
	assign full = cnt == op_num;
	assign result = sum;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Sum wraps at 16 bits
	always_ff @(posedge clk) begin
		if (clear) sum <= '0;
		else if (load) sum <= sum + product[15:0];
	end

	assert property (@(posedge clk) disable iff (rst) load |-> !full)
		else $error("load into a full MAC lane");

endmodule

/* hw/scmp.sv */
// Max pooling comparator
module scmp (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         clear,
	input  logic                         load,
	input  logic [15:0]                  data,
	input  logic [cnn_pkg::OP_NUM_W-1:0] op_num,
	output logic                         full,
	output logic [15:0]                  result
);

	logic [cnn_pkg::OP_NUM_W-1:0] cnt;
	logic [15:0]                  max_q;

	assign full = cnt == op_num;
	assign result = max_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (clear) max_q <= '0;
		else if (load && data > max_q) max_q <= data;
	end

endmodule

/* hw/sacc.sv */
// Average pooling accumulator
module sacc (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         clear,
	input  logic                         load,
	input  logic [15:0]                  data,
	input  logic [cnn_pkg::OP_NUM_W-1:0] op_num,
	input  logic [2:0]                   avg_shift,
	output logic                         full,
	output logic [15:0]                  result
);

	logic [cnn_pkg::OP_NUM_W-1:0] cnt;
	logic [23:0]                  sum;
	logic [23:0]                  scaled;

	assign full = cnt == op_num;

	// Shift the wide sum first so carries above bit 15 still count
	assign scaled = sum >> avg_shift;
	assign result = scaled[15:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (clear) sum <= '0;
		else if (load) sum <= sum + {8'd0, data};
	end

endmodule

/* hw/engine.sv */
// Convolution and pooling sequencer
module engine (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  cnn_pkg::cmd_t     cmd,
	input  logic              empty0,
	input  logic              empty1,
	input  cnn_pkg::operand_t head0,
	input  cnn_pkg::operand_t head1,
	output logic              rd0,
	output logic              rd1,
	output cnn_pkg::result_t  p0_result,
	output cnn_pkg::result_t  p1_result,
	output logic              done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DRAIN,
		ST_WB,
		ST_FINISH
	} state_e;

	state_e state;
	state_e state_nxt;

	logic                           conv0;
	logic                           conv1;
	logic                           mpool;
	logic                           apool;
	logic                           clear;
	logic                           rd_q0;
	logic                           rd_q1;
	logic                           units_full;
	logic [cnn_pkg::LANE_W-1:0]     lane;
	logic [cnn_pkg::LANE_W-1:0]     wb_cnt;
	logic [cnn_pkg::RD_CNT_W-1:0]   rd_cnt;
	logic [cnn_pkg::RD_CNT_W-1:0]   rd_total;
	logic [cnn_pkg::CONV_LANES-1:0] full0;
	logic [cnn_pkg::CONV_LANES-1:0] full1;
	logic [15:0]                    res0 [cnn_pkg::CONV_LANES];
	logic [15:0]                    res1 [cnn_pkg::CONV_LANES];
	logic                           mp_full;
	logic                           ap_full;
	logic [15:0]                    mp_res;
	logic [15:0]                    ap_res;

	assign conv0 = cmd.op == cnn_pkg::OP_CONV_CH0 || cmd.op == cnn_pkg::OP_CONV_DUAL;
	assign conv1 = cmd.op == cnn_pkg::OP_CONV_CH1 || cmd.op == cnn_pkg::OP_CONV_DUAL;
	assign mpool = cmd.op == cnn_pkg::OP_MPOOL;
	assign apool = cmd.op == cnn_pkg::OP_APOOL;
	assign clear = state == ST_IDLE && start;
	assign done = state == ST_FINISH;

	// Lane count is a power of two so a shift gives the reads per stream
	always_comb begin
		if (conv0 || conv1) rd_total = {cmd.op_num, {cnn_pkg::LANE_W{1'b0}}};
		else if (mpool || apool) rd_total = {{cnn_pkg::LANE_W{1'b0}}, cmd.op_num};
		else rd_total = '0;
	end

	// Dual mode reads both streams in lockstep
	always_comb begin
		rd0 = 1'b0;
		rd1 = 1'b0;
		if (state == ST_LOAD && rd_cnt != rd_total) begin
			if (cmd.op == cnn_pkg::OP_CONV_DUAL) begin
				rd0 = !empty0 && !empty1;
				rd1 = !empty0 && !empty1;
			end else if (conv1) begin
				rd1 = !empty1;
			end else begin
				rd0 = !empty0;
			end
		end
	end

	always_comb begin
		case (cmd.op)
			cnn_pkg::OP_CONV_CH0:  units_full = &full0;
			cnn_pkg::OP_CONV_CH1:  units_full = &full1;
			cnn_pkg::OP_CONV_DUAL: units_full = &full0 && &full1;
			cnn_pkg::OP_MPOOL:     units_full = mp_full;
			cnn_pkg::OP_APOOL:     units_full = ap_full;
			default:               units_full = 1'b1;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:   if (start) state_nxt = ST_LOAD;
			ST_LOAD:   if (rd_cnt == rd_total) state_nxt = ST_DRAIN;
			ST_DRAIN:  if (units_full) state_nxt = ST_WB;
			ST_WB:     if (!(conv0 || conv1) || &wb_cnt) state_nxt = ST_FINISH;
			ST_FINISH: if (!start) state_nxt = ST_IDLE;
			default:   state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			rd_q0 <= 1'b0;
			rd_q1 <= 1'b0;
			rd_cnt <= '0;
			lane <= '0;
			wb_cnt <= '0;
		end else begin
			state <= state_nxt;
			rd_q0 <= rd0;
			rd_q1 <= rd1;
			if (clear) begin
				rd_cnt <= '0;
				lane <= '0;
				wb_cnt <= '0;
			end else begin
				if (rd0 || rd1) rd_cnt <= rd_cnt + 1'b1;
				// Pointer moves to the next lane after each returned operand
				if (rd_q0 || rd_q1) lane <= lane + 1'b1;
				if (state == ST_WB) wb_cnt <= wb_cnt + 1'b1;
			end
		end
	end

	for (genvar i = 0; i < cnn_pkg::CONV_LANES; i++) begin : g_lane
		cmac u_cmac0 (
			.clk     (clk),
			.rst     (rst),
			.clear   (clear),
			.load    (rd_q0 && conv0 && lane == i),
			.operand (head0),
			.op_num  (cmd.op_num),
			.full    (full0[i]),
			.result  (res0[i])
		);

		cmac u_cmac1 (
			.clk     (clk),
			.rst     (rst),
			.clear   (clear),
			.load    (rd_q1 && conv1 && lane == i),
			.operand (head1),
			.op_num  (cmd.op_num),
			.full    (full1[i]),
			.result  (res1[i])
		);
	end

	// Pool units see only the data field of stream 0
	scmp u_scmp (
		.clk    (clk),
		.rst    (rst),
		.clear  (clear),
		.load   (rd_q0 && mpool),
		.data   (head0.data),
		.op_num (cmd.op_num),
		.full   (mp_full),
		.result (mp_res)
	);

	sacc u_sacc (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.load      (rd_q0 && apool),
		.data      (head0.data),
		.op_num    (cmd.op_num),
		.avg_shift (cmd.avg_shift),
		.full      (ap_full),
		.result    (ap_res)
	);

	always_comb begin
		p0_result = '0;
		p1_result = '0;
		if (state == ST_WB) begin
			if (conv0) begin
				p0_result.wr_en = 1'b1;
				p0_result.value = res0[wb_cnt];
			end else if (mpool || apool) begin
				p0_result.wr_en = 1'b1;
				p0_result.value = mpool ? mp_res : ap_res;
			end
			if (conv1) begin
				p1_result.wr_en = 1'b1;
				p1_result.value = res1[wb_cnt];
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) start |=> !start || $stable(cmd.op))
		else $error("operation code changed while start was held");

endmodule

/* hw/accel_core.sv */
// CNN accelerator core
module accel_core (
	input  logic              clk,
	input  logic              rst,
	input  logic              push0,
	input  logic              push1,
	input  cnn_pkg::operand_t push_data0,
	input  cnn_pkg::operand_t push_data1,
	input  logic              start,
	input  cnn_pkg::cmd_t     cmd,
	output cnn_pkg::result_t  p0_result,
	output cnn_pkg::result_t  p1_result,
	output logic              done
);

	logic              rd0;
	logic              rd1;
	logic              empty0;
	logic              empty1;
	cnn_pkg::operand_t head0;
	cnn_pkg::operand_t head1;

	operand_fifo u_fifo0 (
		.clk       (clk),
		.rst       (rst),
		.push      (push0),
		.push_data (push_data0),
		.rd        (rd0),
		.head      (head0),
		.empty     (empty0),
		.full      ()
	);

	operand_fifo u_fifo1 (
		.clk       (clk),
		.rst       (rst),
		.push      (push1),
		.push_data (push_data1),
		.rd        (rd1),
		.head      (head1),
		.empty     (empty1),
		.full      ()
	);

	engine u_engine (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.cmd       (cmd),
		.empty0    (empty0),
		.empty1    (empty1),
		.head0     (head0),
		.head1     (head1),
		.rd0       (rd0),
		.rd1       (rd1),
		.p0_result (p0_result),
		.p1_result (p1_result),
		.done      (done)
	);

endmodule

/* bench/tb_accel.sv */
// Accelerator core testbench
module tb_accel;

	localparam int N_TESTS = 7;
	localparam int HOLD_CYCLES = 3;
	localparam int WATCHDOG_CYCLES = N_TESTS * 200 + 1000;

	logic              clk;
	logic              rst;
	logic              push0;
	logic              push1;
	cnn_pkg::operand_t push_data0;
	cnn_pkg::operand_t push_data1;
	logic              start;
	cnn_pkg::cmd_t     cmd;
	cnn_pkg::result_t  p0_result;
	cnn_pkg::result_t  p1_result;
	logic              done;

	cnn_pkg::cmd_t     tests [N_TESTS];
	cnn_pkg::operand_t ops0 [cnn_pkg::FIFO_DEPTH];
	cnn_pkg::operand_t ops1 [cnn_pkg::FIFO_DEPTH];
	cnn_pkg::result_t  exp_p0 [cnn_pkg::CONV_LANES];
	cnn_pkg::result_t  exp_p1 [cnn_pkg::CONV_LANES];
	int                n_wb;
	int                cur_test;
	logic [31:0]       lcg_state;

	accel_core u_accel_core (
		.clk        (clk),
		.rst        (rst),
		.push0      (push0),
		.push1      (push1),
		.push_data0 (push_data0),
		.push_data1 (push_data1),
		.start      (start),
		.cmd        (cmd),
		.p0_result  (p0_result),
		.p1_result  (p1_result),
		.done       (done)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic draw_operand(output cnn_pkg::operand_t op);
		lcg_state = lcg_next(lcg_state);
		op.data = lcg_state[31:16];
		lcg_state = lcg_next(lcg_state);
		op.weight = lcg_state[31:16];
	endtask

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_result(input int port, input cnn_pkg::result_t exp_res,
			input cnn_pkg::result_t act_res);
		// Value only matters on a strobe
		if (act_res.wr_en !== exp_res.wr_en ||
				(exp_res.wr_en && act_res.value !== exp_res.value)) begin
			$display("** Error at time %0t: entry %0d p%0d expected %0b/%04h, got %0b/%04h",
				$time, cur_test, port, exp_res.wr_en, exp_res.value,
				act_res.wr_en, act_res.value);
			abort_run();
		end
	endtask

	task automatic check_done(input logic exp_done, input logic act_done);
		if (act_done !== exp_done) begin
			$display("** Error at time %0t: entry %0d done expected %0b, got %0b",
				$time, cur_test, exp_done, act_done);
			abort_run();
		end
	endtask

	task automatic check_quiet(input logic exp_done);
		check_done(exp_done, done);
		check_result(0, '0, p0_result);
		check_result(1, '0, p1_result);
	endtask

	// Round r feeds lane i from stream position r*lanes+i
	function automatic logic [15:0] lane_sum(input int bank, input int lane, input int rounds);
		logic [15:0]       sum;
		logic [31:0]       prod;
		cnn_pkg::operand_t w;
		sum = '0;
		for (int r = 0; r < rounds; r++) begin
			w = (bank == 0) ? ops0[r * cnn_pkg::CONV_LANES + lane] :
				ops1[r * cnn_pkg::CONV_LANES + lane];
			prod = {16'd0, w.data} * {16'd0, w.weight};
			sum = sum + prod[15:0];
		end
		return sum;
	endfunction

	task automatic push_operands(input cnn_pkg::cmd_t c);
		int n0;
		int n1;
		int conv_n;
		conv_n = int'(c.op_num) * cnn_pkg::CONV_LANES;
		n0 = 0;
		n1 = 0;
		case (c.op)
			cnn_pkg::OP_CONV_CH0: n0 = conv_n;
			cnn_pkg::OP_CONV_CH1: n1 = conv_n;
			cnn_pkg::OP_CONV_DUAL: begin
				n0 = conv_n;
				n1 = conv_n;
			end
			cnn_pkg::OP_MPOOL, cnn_pkg::OP_APOOL: n0 = int'(c.op_num);
			default: n0 = 0;
		endcase
		for (int k = 0; k < n0 || k < n1; k++) begin
			@(negedge clk);
			push0 = k < n0;
			push1 = k < n1;
			if (k < n0) begin
				draw_operand(push_data0);
				ops0[k] = push_data0;
			end
			if (k < n1) begin
				draw_operand(push_data1);
				ops1[k] = push_data1;
			end
		end
		@(negedge clk);
		push0 = 1'b0;
		push1 = 1'b0;
	endtask

	task automatic build_expected(input cnn_pkg::cmd_t c);
		logic [15:0] max_val;
		logic [23:0] acc;
		logic [23:0] scaled;
		for (int i = 0; i < cnn_pkg::CONV_LANES; i++) begin
			exp_p0[i] = '0;
			exp_p1[i] = '0;
		end
		n_wb = 1;
		if (c.op == cnn_pkg::OP_CONV_CH0 || c.op == cnn_pkg::OP_CONV_CH1 ||
				c.op == cnn_pkg::OP_CONV_DUAL) begin
			n_wb = cnn_pkg::CONV_LANES;
			for (int i = 0; i < cnn_pkg::CONV_LANES; i++) begin
				if (c.op != cnn_pkg::OP_CONV_CH1)
					exp_p0[i] = '{wr_en: 1'b1, value: lane_sum(0, i, int'(c.op_num))};
				if (c.op != cnn_pkg::OP_CONV_CH0)
					exp_p1[i] = '{wr_en: 1'b1, value: lane_sum(1, i, int'(c.op_num))};
			end
		end else if (c.op == cnn_pkg::OP_MPOOL) begin
			max_val = '0;
			for (int k = 0; k < int'(c.op_num); k++) begin
				if (ops0[k].data > max_val) max_val = ops0[k].data;
			end
			exp_p0[0] = '{wr_en: 1'b1, value: max_val};
		end else begin
			acc = '0;
			for (int k = 0; k < int'(c.op_num); k++) begin
				acc = acc + {8'd0, ops0[k].data};
			end
			// Wide sum scaled before truncation
			scaled = acc >> c.avg_shift;
			exp_p0[0] = '{wr_en: 1'b1, value: scaled[15:0]};
		end
	endtask

	task automatic run_entry(input cnn_pkg::cmd_t c);
		push_operands(c);
		build_expected(c);
		start = 1'b1;
		cmd = c;
		@(negedge clk);
		while (!p0_result.wr_en && !p1_result.wr_en) begin
			check_done(1'b0, done);
			@(negedge clk);
		end
		for (int k = 0; k < n_wb; k++) begin
			check_result(0, exp_p0[k], p0_result);
			check_result(1, exp_p1[k], p1_result);
			check_done(1'b0, done);
			@(negedge clk);
		end
		// Done stays up while start is held
		repeat (HOLD_CYCLES) begin
			check_quiet(1'b1);
			@(negedge clk);
		end
		check_quiet(1'b1);
		start = 1'b0;
		@(negedge clk);
		check_quiet(1'b0);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests did not finish within %0d clock periods", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		push0 = 1'b0;
		push1 = 1'b0;
		push_data0 = '0;
		push_data1 = '0;
		start = 1'b0;
		cmd = '0;
		cur_test = -1;
		lcg_state = 32'd17;
		tests[0] = '{op: cnn_pkg::OP_CONV_CH0, op_num: 8'd3, avg_shift: 3'd0};
		tests[1] = '{op: cnn_pkg::OP_CONV_CH1, op_num: 8'd2, avg_shift: 3'd0};
		tests[2] = '{op: cnn_pkg::OP_CONV_DUAL, op_num: 8'd2, avg_shift: 3'd0};
		tests[3] = '{op: cnn_pkg::OP_MPOOL, op_num: 8'd5, avg_shift: 3'd0};
		tests[4] = '{op: cnn_pkg::OP_APOOL, op_num: 8'd4, avg_shift: 3'd2};
		tests[5] = '{op: cnn_pkg::OP_CONV_DUAL, op_num: 8'd5, avg_shift: 3'd0};
		tests[6] = '{op: cnn_pkg::OP_APOOL, op_num: 8'd7, avg_shift: 3'd3};
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// Quiet outputs before any start
		repeat (5) begin
			@(negedge clk);
			check_quiet(1'b0);
		end
		for (int t = 0; t < N_TESTS; t++) begin
			cur_test = t;
			run_entry(tests[t]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* compile.f */
hw/cnn_pkg.sv
hw/operand_fifo.sv
hw/cmac.sv
hw/scmp.sv
hw/sacc.sv
hw/engine.sv
hw/accel_core.sv
bench/tb_accel.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_accel
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
